/* design/ahb_pkg.sv */
package ahb_pkg;

  localparam int mem_words = 256;
  localparam int mem_wait_cycles = 2;
  localparam int mem_addr_bits = $clog2(mem_words);
  localparam int wait_cnt_bits = $clog2(mem_wait_cycles + 1);
  localparam logic [31:0] mem_limit = 32'(mem_words * 4); // First byte past the array.

  localparam logic [2:0] hsize_word = 3'b010;
  localparam logic [2:0] hburst_single = 3'b000;

  typedef enum logic [1:0] {
    TRANS_IDLE = 2'b00,
    TRANS_NONSEQ = 2'b10
  } htrans_e;

  typedef enum logic [1:0] {
    M_IDLE,
    M_ADDR,
    M_DATA
  } master_state_e;

  typedef enum logic {
    OWN_INSTR,
    OWN_DATA
  } owner_e;

  typedef enum logic [1:0] {
    S_WAIT,
    S_RESP1,
    S_RESP2
  } sram_state_e;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic write;
  } mem_req_t;

  typedef struct packed {
    mem_req_t req;
    logic instr;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic err;
  } mem_rsp_t;

endpackage

/* design/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
  input logic clk,
  input logic rst,
  input logic instr_valid,
  input ahb_pkg::mem_req_t instr_req,
  output logic instr_ready,
  output ahb_pkg::mem_rsp_t instr_rsp,
  input logic data_valid,
  input ahb_pkg::mem_req_t data_req,
  output logic data_ready,
  output ahb_pkg::mem_rsp_t data_rsp,
  output logic bus_valid,
  output ahb_pkg::bus_req_t bus_req,
  input logic bus_ready,
  input ahb_pkg::mem_rsp_t bus_rsp
);
  import ahb_pkg::*;

  owner_e owner;
  owner_e last;
  owner_e pick;
  logic busy;
  logic instr_own;

  // Round robin only matters on a tie.
  always_comb begin
    if (instr_valid && data_valid) begin
      if (last == OWN_INSTR) begin
        pick = OWN_DATA;
      end else begin
        pick = OWN_INSTR;
      end
    end else if (instr_valid) begin
      pick = OWN_INSTR;
    end else begin
      pick = OWN_DATA;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy <= 1'b0;
      owner <= OWN_INSTR;
      last <= OWN_DATA; // Instruction port wins the first tie.
    end else if (!busy) begin
      if (instr_valid || data_valid) begin
        busy <= 1'b1;
        owner <= pick;
      end
    end else if (bus_ready) begin
      busy <= 1'b0;
      last <= owner;
    end
  end

  assign instr_own = (owner == OWN_INSTR);

  assign bus_valid = busy;
  assign bus_req = '{req: instr_own ? instr_req : data_req, instr: instr_own};

  assign instr_ready = bus_ready && instr_own;
  assign data_ready = bus_ready && !instr_own;
  assign instr_rsp = instr_own ? bus_rsp : '0;
  assign data_rsp = instr_own ? '0 : bus_rsp;

endmodule

/* design/ahb_master.sv */
`timescale 1ns/10ps

module ahb_master (
  input logic clk,
  input logic rst,
  input logic bus_valid,
  input ahb_pkg::bus_req_t bus_req,
  output logic bus_ready,
  output ahb_pkg::mem_rsp_t bus_rsp,
  output logic [31:0] haddr,
  output ahb_pkg::htrans_e htrans,
  output logic hwrite,
  output logic [2:0] hsize,
  output logic [2:0] hburst,
  output logic [3:0] hprot,
  output logic hmastlock,
  output logic [31:0] hwdata,
  input logic [31:0] hrdata,
  input logic hready,
  input logic hresp
);
  import ahb_pkg::*;

  master_state_e state;

  logic [31:0] haddr_q;
  logic [31:0] hwdata_q;
  logic hwrite_q;
  logic [3:0] hprot_q;
  logic accept;

  assign accept = (state == M_IDLE) && bus_valid;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= M_IDLE;
    end else begin
      case (state)
        M_IDLE: begin
          if (bus_valid) begin
            state <= M_ADDR;
          end
        end
        M_ADDR: begin
          if (hready) begin // Address phase taken by the slave.
            state <= M_DATA;
          end
        end
        M_DATA: begin
          if (hready) begin
            state <= M_IDLE;
          end
        end
        default: begin
          state <= M_IDLE;
        end
      endcase
    end
  end

  // Transfer attributes held from accept to the end of the data phase.
  always_ff @(posedge clk) begin
    if (accept) begin
      haddr_q <= bus_req.req.addr;
      hwdata_q <= bus_req.req.wdata;
      hwrite_q <= bus_req.req.write;
      hprot_q <= {3'b000, ~bus_req.instr}; // Bit 0 set for data access.
    end
  end

  assign haddr = haddr_q;
  assign htrans = (state == M_ADDR) ? TRANS_NONSEQ : TRANS_IDLE;
  assign hwrite = hwrite_q;
  assign hsize = hsize_word;
  assign hburst = hburst_single;
  assign hprot = hprot_q;
  assign hmastlock = 1'b0;
  assign hwdata = hwdata_q;

  // Completion follows the slave's hready in the data phase.
  assign bus_ready = (state == M_DATA) && hready;
  assign bus_rsp = '{rdata: hrdata, err: hresp};

endmodule

/* design/ahb_sram.sv */
`timescale 1ns/10ps

module ahb_sram (
  input logic clk,
  input logic rst,
  input logic [31:0] haddr,
  input ahb_pkg::htrans_e htrans,
  input logic hwrite,
  input logic [31:0] hwdata,
  output logic [31:0] hrdata,
  output logic hready,
  output logic hresp
);
  import ahb_pkg::*;

  logic [31:0] mem [mem_words];

  sram_state_e state;
  logic active;
  logic [wait_cnt_bits-1:0] wait_cnt;
  logic [mem_addr_bits-1:0] idx_q;
  logic write_q;
  logic err_q;
  logic start;
  logic resp_ok;

  assign start = hready && (htrans == TRANS_NONSEQ);
  assign resp_ok = (state == S_RESP2) && !err_q;

  assign hready = (state == S_RESP2) || ((state == S_WAIT) && !active);
  assign hresp = (state == S_RESP1) || ((state == S_RESP2) && err_q);
  assign hrdata = (resp_ok && !write_q) ? mem[idx_q] : '0;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= S_WAIT;
      active <= 1'b0;
      wait_cnt <= '0;
    end else begin
      case (state)
        S_WAIT: begin
          if (active) begin
            if (wait_cnt == wait_cnt_bits'(mem_wait_cycles - 1)) begin
              active <= 1'b0;
              state <= err_q ? S_RESP1 : S_RESP2;
            end
            wait_cnt <= wait_cnt + 1'b1;
          end else if (start) begin
            active <= 1'b1;
            wait_cnt <= '0;
          end
        end
        S_RESP1: begin
          state <= S_RESP2; // Second ERROR cycle.
        end
        default: begin
          state <= S_WAIT;
          if (start) begin // Next address phase overlapping the response.
            active <= 1'b1;
            wait_cnt <= '0;
          end
        end
      endcase
    end
  end

  // Address phase controls.
  always_ff @(posedge clk) begin
    if (start) begin
      idx_q <= haddr[mem_addr_bits+1:2];
      write_q <= hwrite;
      err_q <= (haddr >= mem_limit);
    end
  end

  // Write data arrives in the data phase.
  always_ff @(posedge clk) begin
    if (resp_ok && write_q) begin
      mem[idx_q] <= hwdata;
    end
  end

endmodule

/* design/ahb_subsys.sv */
`timescale 1ns/10ps

module ahb_subsys (
  input logic clk,
  input logic rst,
  input logic instr_valid,
  input ahb_pkg::mem_req_t instr_req,
  output logic instr_ready,
  output ahb_pkg::mem_rsp_t instr_rsp,
  input logic data_valid,
  input ahb_pkg::mem_req_t data_req,
  output logic data_ready,
  output ahb_pkg::mem_rsp_t data_rsp
);
  import ahb_pkg::*;

  logic bus_valid;
  bus_req_t bus_req;
  logic bus_ready;
  mem_rsp_t bus_rsp;

  logic [31:0] haddr;
  htrans_e htrans;
  logic hwrite;
  logic [31:0] hwdata;
  logic [31:0] hrdata;
  logic hready;
  logic hresp;

  mem_arbiter arb (
    .clk(clk),
    .rst(rst),
    .instr_valid(instr_valid),
    .instr_req(instr_req),
    .instr_ready(instr_ready),
    .instr_rsp(instr_rsp),
    .data_valid(data_valid),
    .data_req(data_req),
    .data_ready(data_ready),
    .data_rsp(data_rsp),
    .bus_valid(bus_valid),
    .bus_req(bus_req),
    .bus_ready(bus_ready),
    .bus_rsp(bus_rsp)
  );

  ahb_master master (
    .clk(clk),
    .rst(rst),
    .bus_valid(bus_valid),
    .bus_req(bus_req),
    .bus_ready(bus_ready),
    .bus_rsp(bus_rsp),
    .haddr(haddr),
    .htrans(htrans),
    .hwrite(hwrite),
    .hsize(),
    .hburst(),
    .hprot(),
    .hmastlock(),
    .hwdata(hwdata),
    .hrdata(hrdata),
    .hready(hready),
    .hresp(hresp)
  );

  ahb_sram sram (
    .clk(clk),
    .rst(rst),
    .haddr(haddr),
    .htrans(htrans),
    .hwrite(hwrite),
    .hwdata(hwdata),
    .hrdata(hrdata),
    .hready(hready),
    .hresp(hresp)
  );

endmodule

/* dv/ahb_subsys_asserts.sv */
`timescale 1ns/10ps

module ahb_subsys_asserts (
  input logic clk,
  input logic rst,
  input ahb_pkg::master_state_e state,
  input ahb_pkg::htrans_e htrans,
  input logic [31:0] haddr,
  input logic hwrite,
  input logic [31:0] hwdata,
  input logic hready,
  input logic hresp
);
  import ahb_pkg::*;

  // One NONSEQ cycle per accepted transfer.
  nonseq_single: assert property (@(posedge clk) disable iff (!rst)
    (htrans == TRANS_NONSEQ && hready) |=> (htrans == TRANS_IDLE))
    else $error("htrans stayed NONSEQ after the address phase");

  data_phase_stable: assert property (@(posedge clk) disable iff (!rst)
    (state == M_DATA && !hready) |=> ($stable(haddr) && $stable(hwrite) && $stable(hwdata)))
    else $error("haddr, hwrite or hwdata changed during the data phase");

  error_first: assert property (@(posedge clk) disable iff (!rst)
    (hresp && !hready) |=> (hresp && hready))
    else $error("ERROR response not completed in its second cycle");

  error_second: assert property (@(posedge clk) disable iff (!rst)
    (hresp && hready) |-> $past(hresp && !hready))
    else $error("ERROR response ended without its first cycle");

endmodule

bind ahb_master ahb_subsys_asserts master_asserts (
  .clk(clk),
  .rst(rst),
  .state(state),
  .htrans(htrans),
  .haddr(haddr),
  .hwrite(hwrite),
  .hwdata(hwdata),
  .hready(hready),
  .hresp(hresp)
);

/* dv/ahb_subsys_tb.sv */
`timescale 1ns/10ps

module ahb_subsys_tb;
  import ahb_pkg::*;

  localparam int num_req = 200;
  localparam int low_words = 64;
  // Fill, both traffic streams and the final sweep, at most 10 cycles each.
  localparam int max_cycles = (2 * mem_words + 2 * num_req) * 10 + 1000;

  logic clk;
  logic rst;
  logic instr_valid;
  mem_req_t instr_req;
  logic instr_ready;
  mem_rsp_t instr_rsp;
  logic data_valid;
  mem_req_t data_req;
  logic data_ready;
  mem_rsp_t data_rsp;

  logic [31:0] model [mem_words];
  logic [31:0] instr_addr [num_req];
  logic [1:0] instr_gap [num_req];
  logic [31:0] data_addr [num_req];
  logic [31:0] data_wdata [num_req];
  logic data_write [num_req];
  logic [1:0] data_gap [num_req];

  int errors;
  int checks;
  int monitor_errors = 0;
  int cycles = 0;
  logic fair_pending = 1'b0;
  owner_e fair_next = OWN_INSTR;

  ahb_subsys uut (
    .clk(clk),
    .rst(rst),
    .instr_valid(instr_valid),
    .instr_req(instr_req),
    .instr_ready(instr_ready),
    .instr_rsp(instr_rsp),
    .data_valid(data_valid),
    .data_req(data_req),
    .data_ready(data_ready),
    .data_rsp(data_rsp)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Fill value built from the whole word index.
  function automatic logic [31:0] fill_word(input int idx);
    return 32'h5a5a_0000 | 32'(idx * 4);
  endfunction

  // Word-aligned address, one in ten above the memory.
  function automatic logic [31:0] pick_addr(input int unsigned lo, input int unsigned n);
    if ($urandom_range(9) == 0) begin
      return (32'($urandom) & 32'hffff_fffc) | mem_limit;
    end
    return (lo + $urandom_range(n - 1)) << 2;
  endfunction

  task automatic report_mismatch(input string port, input string what,
                                 input logic [31:0] addr, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH at %0t: %s port %s for addr %h, got %h expected %h",
             $time, port, what, addr, got, exp);
    errors++;
  endtask

  task automatic check_rsp(input string port, input logic [31:0] addr,
                           input logic write, input mem_rsp_t rsp);
    logic in_range;
    logic [31:0] exp;
    in_range = (addr < mem_limit);
    exp = in_range ? model[addr[mem_addr_bits+1:2]] : 32'h0;
    checks++;
    if (rsp.err !== !in_range) begin
      report_mismatch(port, "err", addr, 32'(rsp.err), 32'(!in_range));
    end
    if (!write && rsp.rdata !== exp) begin
      report_mismatch(port, "rdata", addr, rsp.rdata, exp);
    end
  endtask

  task automatic data_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic write);
    mem_rsp_t rsp;
    data_valid = 1'b1;
    data_req = '{addr: addr, wdata: wdata, write: write};
    @(negedge clk);
    while (!data_ready) @(negedge clk);
    rsp = data_rsp;
    check_rsp("data", addr, write, rsp);
    if (write && addr < mem_limit) begin
      model[addr[mem_addr_bits+1:2]] = wdata;
    end
    @(posedge clk);
    #1;
    data_valid = 1'b0;
    data_req = '0;
  endtask

  task automatic instr_fetch(input logic [31:0] addr);
    mem_rsp_t rsp;
    instr_valid = 1'b1;
    instr_req = '{addr: addr, wdata: 32'h0, write: 1'b0};
    @(negedge clk);
    while (!instr_ready) @(negedge clk);
    rsp = instr_rsp;
    check_rsp("instr", addr, 1'b0, rsp);
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    instr_req = '0;
  endtask

  task automatic idle_cycles(input logic [1:0] n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Handshake rules and round robin order, sampled mid cycle.
  always @(negedge clk) begin
    if (instr_ready && !instr_valid) begin
      $display("Error at %0t: instr_ready high without a request", $time);
      monitor_errors++;
    end
    if (data_ready && !data_valid) begin
      $display("Error at %0t: data_ready high without a request", $time);
      monitor_errors++;
    end
    if (instr_ready && data_ready) begin
      $display("Error at %0t: both ports got ready in one cycle", $time);
      monitor_errors++;
    end else if (instr_ready || data_ready) begin
      if (fair_pending && (instr_ready ? OWN_INSTR : OWN_DATA) != fair_next) begin
        $display("Error at %0t: a port was granted twice while the other waited", $time);
        monitor_errors++;
      end
      fair_pending = instr_ready ? data_valid : instr_valid; // Other port waiting.
      fair_next = instr_ready ? OWN_DATA : OWN_INSTR;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > max_cycles) begin
      $display("Timeout: requests did not complete");
      $display("Checks: %0d, errors: %0d", checks, errors + monitor_errors);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h2c12_edaf));
    errors = 0;
    checks = 0;
    rst = 1'b0;
    instr_valid = 1'b0;
    instr_req = '0;
    data_valid = 1'b0;
    data_req = '0;
    for (int i = 0; i < mem_words; i++) begin
      model[i] = 32'h0;
    end
    // Instruction port stays in the low words, data writes stay above them.
    for (int k = 0; k < num_req; k++) begin
      instr_addr[k] = pick_addr(0, low_words);
      instr_gap[k] = 2'($urandom_range(3));
      data_write[k] = 1'($urandom_range(1));
      if (data_write[k]) begin
        data_addr[k] = pick_addr(low_words, mem_words - low_words);
      end else begin
        data_addr[k] = pick_addr(0, mem_words);
      end
      data_wdata[k] = $urandom;
      data_gap[k] = 2'($urandom_range(3));
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b1;
    idle_cycles(2'd2);
    for (int i = 0; i < mem_words; i++) begin
      data_access(32'(i * 4), fill_word(i), 1'b1);
    end
    fork
      begin
        for (int k = 0; k < num_req; k++) begin
          instr_fetch(instr_addr[k]);
          idle_cycles(instr_gap[k]);
        end
      end
      begin
        for (int k = 0; k < num_req; k++) begin
          data_access(data_addr[k], data_wdata[k], data_write[k]);
          idle_cycles(data_gap[k]);
        end
      end
    join
    for (int i = 0; i < mem_words; i++) begin
      data_access(32'(i * 4), 32'h0, 1'b0); // Final sweep against the model.
    end
    $display("Checks: %0d, errors: %0d", checks, errors + monitor_errors);
    if (errors + monitor_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* ahb_subsys.f */
design/ahb_pkg.sv
design/mem_arbiter.sv
design/ahb_master.sv
design/ahb_sram.sv
design/ahb_subsys.sv
dv/ahb_subsys_asserts.sv
dv/ahb_subsys_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module ahb_subsys_tb -f ahb_subsys.f -o ahb_subsys_sim \
  && ./obj_dir/ahb_subsys_sim | tee /dev/stderr | grep "Finished with no errors" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
